// ==== rv32_pipe.f ====
+incdir+common
common/rv32_pkg.sv
common/stage_if.sv
rtl/decode/register_file.sv
rtl/decode/decode_stage.sv
rtl/fetch_unit.sv
rtl/execute_stage.sv
rtl/retire_unit.sv
rtl/rv32_pipe_top.sv
bench/rv32_iss.sv
bench/rv32_pipe_tb.sv

// ==== run_rv32_pipe.sh ====
#!/bin/sh
# compile and run the rv32_pipe testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module rv32_pipe_tb -Mdir obj_dir -f rv32_pipe.f \
	&& ./obj_dir/Vrv32_pipe_tb | tee sim.log
# the log decides the result
grep -q "PASS: all tests" sim.log && echo "rv32_pipe: passed" \
	|| { echo "rv32_pipe: failed"; exit 1; }

// ==== bench/rv32_pipe_tb.sv ====
`include "rv32_consts.svh"

module rv32_pipe_tb import rv32_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PROG_LEN = 64;
	localparam word_t HALT_PC = word_t'((PROG_LEN - 1) * 4);

	logic      clock;
	logic      reset;
	logic      fetch_req_valid_o;
	word_t     fetch_addr_o;
	logic      fetch_req_ready_i;
	logic      fetch_rsp_valid_i;
	inst_t     fetch_rsp_inst_i;
	logic      commit_valid_o;
	word_t     commit_pc_o;
	inst_t     commit_inst_o;
	logic      commit_wen_o;
	reg_addr_t commit_rd_o;
	word_t     commit_data_o;

	inst_t     imem [0:PROG_LEN-1];
	logic      pending;
	word_t     req_addr;
	int        wait_cycles;
	logic      seen_req;
	logic      held;
	word_t     prev_addr;
	logic      rsp_ctrl;
	logic      commit_ctrl;

	word_t     exp_pc;
	word_t     exp_next_pc;
	logic      exp_wen;
	reg_addr_t exp_rd;
	word_t     exp_data;
	inst_t     exp_inst;

	rv32_pipe_top UUT (.*);

	rv32_iss iss (
		.clock_i   (clock),
		.reset_i   (reset),
		.step_i    (commit_valid_o),
		.inst_i    (exp_inst),
		.pc_o      (exp_pc),
		.next_pc_o (exp_next_pc),
		.wen_o     (exp_wen),
		.rd_o      (exp_rd),
		.data_o    (exp_data)
	);

	assign exp_inst = imem[exp_pc[7:2]];

	function automatic logic is_control(inst_t inst);
		return inst[6:0] == `RV32_OPC_JAL || inst[6:0] == `RV32_OPC_JALR ||
			inst[6:0] == `RV32_OPC_BRANCH;
	endfunction

	assign rsp_ctrl = fetch_rsp_valid_i && is_control(fetch_rsp_inst_i);
	assign commit_ctrl = commit_valid_o && is_control(commit_inst_o);

	function automatic inst_t itype(int imm, int rs1, int f3, int rd, logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic inst_t rtype(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `RV32_OPC_OP};
	endfunction

	function automatic inst_t utype(int imm, int rd, logic [6:0] opc);
		return {imm[19:0], rd[4:0], opc};
	endfunction

	function automatic inst_t btype(int off, int rs2, int rs1, int f3);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
			`RV32_OPC_BRANCH};
	endfunction

	function automatic inst_t jtype(int off, int rd);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `RV32_OPC_JAL};
	endfunction

	// control flow only jumps forward so every run ends at the halt word
	function automatic inst_t random_inst(int idx);
		int kind;
		int rd;
		int rs1;
		int rs2;
		int f3;
		int f7;
		int imm;
		int span;
		kind = $urandom % 16;
		rd = $urandom % 8;
		rs1 = $urandom % 8;
		rs2 = $urandom % 8;
		f3 = $urandom % 8;
		f7 = 0;
		imm = $urandom;
		span = PROG_LEN - 1 - idx;
		case (kind)
			0: return utype(imm, rd, `RV32_OPC_LUI);
			1: return utype(imm, rd, `RV32_OPC_AUIPC);
			2, 3, 4, 5: begin
				if (f3 == 1 || f3 == 5) begin
					imm = (f3 == 5 && $urandom % 2 == 1) ? 1024 + (imm & 31) : imm & 31;
				end
				return itype(imm, rs1, f3, rd, `RV32_OPC_OP_IMM);
			end
			6, 7, 8, 9: begin
				if ((f3 == 0 || f3 == 5) && $urandom % 2 == 1) begin
					f7 = 32;
				end
				return rtype(f7, rs2, rs1, f3, rd);
			end
			10, 11: begin
				f3 = (f3 < 2) ? f3 : ((f3 < 4) ? f3 + 4 : f3);
				return btype(4 * (1 + $urandom % span), rs2, rs1, f3);
			end
			12: return jtype(4 * (1 + $urandom % span), rd);
			13: return itype(4 * (idx + 1 + $urandom % span), 0, 0, rd, `RV32_OPC_JALR);
			// load opcode is not supported here
			14: return {imm[24:0], 7'b0000011};
			default: return itype(imm, rs1, 0, rd, `RV32_OPC_OP_IMM);
		endcase
	endfunction

	task automatic build_program();
		imem[0] = utype(32'h12345, 1, `RV32_OPC_LUI);
		imem[1] = itype(32'h678, 1, 0, 2, `RV32_OPC_OP_IMM);
		imem[2] = itype(-5, 0, 0, 3, `RV32_OPC_OP_IMM);
		// x2 at distance 2 and x1 at distance 3
		imem[3] = rtype(0, 1, 2, 0, 4);
		imem[4] = rtype(32, 3, 4, 0, 5);
		imem[5] = utype(1, 6, `RV32_OPC_AUIPC);
		imem[6] = rtype(0, 5, 6, 4, 7);
		imem[7] = rtype(32, 2, 3, 5, 8);
		imem[8] = itype(5, 1, 0, 0, `RV32_OPC_OP_IMM);
		imem[9] = btype(8, 1, 1, 0);
		imem[10] = itype(1, 0, 0, 9, `RV32_OPC_OP_IMM);
		imem[11] = btype(8, 1, 1, 1);
		imem[12] = utype(0, 10, `RV32_OPC_AUIPC);
		imem[13] = itype(12, 10, 0, 11, `RV32_OPC_JALR);
		imem[14] = itype(7, 0, 0, 13, `RV32_OPC_OP_IMM);
		imem[15] = jtype(8, 12);
		imem[16] = itype(3, 0, 0, 14, `RV32_OPC_OP_IMM);
		imem[17] = {25'h1abcdef, 7'b0000011};
		for (int i = 18; i < PROG_LEN - 1; i++) begin
			imem[i] = random_inst(i);
		end
		imem[PROG_LEN - 1] = jtype(0, 0);
	endtask

	task automatic report_mismatch(input string name, input word_t got, input word_t expected);
		$display("Fail at %0d ns: %s = %h, expected %h", $time, name, got, expected);
		$display("FAIL: see errors above");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic stop_with_error(input string what);
		$display("Error at %0d ns: %s", $time, what);
		$display("FAIL: see errors above");
		$fatal(1, "stopping at the first error");
	endtask

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// instruction memory with 0 to 3 idle cycles per response
	always @(negedge clock) begin
		if (reset) begin
			pending = 1'b0;
			fetch_rsp_valid_i = 1'b0;
			fetch_req_ready_i = 1'b0;
		end else begin
			fetch_rsp_valid_i = 1'b0;
			if (pending && wait_cycles == 0) begin
				fetch_rsp_valid_i = 1'b1;
				fetch_rsp_inst_i = imem[req_addr[7:2]];
				pending = 1'b0;
			end else if (pending) begin
				wait_cycles = wait_cycles - 1;
			end
			fetch_req_ready_i = ($urandom % 4) != 0;
			// transfer happens on the coming rising edge
			if (fetch_req_valid_o && fetch_req_ready_i) begin
				pending = 1'b1;
				req_addr = fetch_addr_o;
				wait_cycles = $urandom % 4;
			end
		end
	end

	always @(posedge clock) begin
		if (reset) begin
			seen_req <= 1'b0;
			held <= 1'b0;
		end else begin
			seen_req <= seen_req || fetch_req_valid_o;
			held <= fetch_req_valid_o && !fetch_req_ready_i;
		end
		prev_addr <= fetch_addr_o;
	end

	initial begin
		void'($urandom(67865));
		reset = 1'b1;
		fetch_req_ready_i = 1'b0;
		fetch_rsp_valid_i = 1'b0;
		fetch_rsp_inst_i = '0;
		pending = 1'b0;
		build_program();
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset <= 1'b0;
		do begin
			@(negedge clock);
		end while (!(commit_valid_o && commit_pc_o == HALT_PC));
		repeat (2) @(negedge clock);
		$display("PASS: all tests");
		$finish;
	end

	initial begin
		repeat (PROG_LEN * 12 + 2) @(posedge clock);
		stop_with_error("watchdog expired before the halt instruction retired");
	end

	reset_quiet: assert property (@(posedge clock)
		($past(reset) || $past(reset, 2)) |-> !commit_valid_o)
		else report_mismatch("commit_valid_o", 32'($sampled(commit_valid_o)), 32'd0);

	first_fetch: assert property (@(posedge clock) disable iff (reset)
		(fetch_req_valid_o && !seen_req) |-> fetch_addr_o == `RV32_RESET_PC)
		else report_mismatch("fetch_addr_o", $sampled(fetch_addr_o), `RV32_RESET_PC);

	commit_pc: assert property (@(posedge clock) disable iff (reset)
		commit_valid_o |-> commit_pc_o == exp_pc)
		else report_mismatch("commit_pc_o", $sampled(commit_pc_o), $sampled(exp_pc));

	commit_inst: assert property (@(posedge clock) disable iff (reset)
		commit_valid_o |-> commit_inst_o == exp_inst)
		else report_mismatch("commit_inst_o", $sampled(commit_inst_o), $sampled(exp_inst));

	commit_wen: assert property (@(posedge clock) disable iff (reset)
		commit_valid_o |-> commit_wen_o == exp_wen)
		else report_mismatch("commit_wen_o", 32'($sampled(commit_wen_o)),
			32'($sampled(exp_wen)));

	commit_rd: assert property (@(posedge clock) disable iff (reset)
		commit_valid_o |-> commit_rd_o == exp_rd)
		else report_mismatch("commit_rd_o", 32'($sampled(commit_rd_o)),
			32'($sampled(exp_rd)));

	commit_data: assert property (@(posedge clock) disable iff (reset)
		(commit_valid_o && exp_wen) |-> commit_data_o == exp_data)
		else report_mismatch("commit_data_o", $sampled(commit_data_o), $sampled(exp_data));

	// response to commit is always three edges
	commit_latency: assert property (@(posedge clock) disable iff (reset)
		commit_valid_o == $past(fetch_rsp_valid_i, 3))
		else report_mismatch("commit_valid_o", 32'($sampled(commit_valid_o)),
			32'(!$sampled(commit_valid_o)));

	redirect_target: assert property (@(posedge clock) disable iff (reset)
		commit_ctrl |-> fetch_addr_o == exp_next_pc)
		else report_mismatch("fetch_addr_o", $sampled(fetch_addr_o), $sampled(exp_next_pc));

	ctrl_stall: assert property (@(posedge clock) disable iff (reset)
		($past(rsp_ctrl) || $past(rsp_ctrl, 2)) |-> !fetch_req_valid_o)
		else report_mismatch("fetch_req_valid_o", 32'($sampled(fetch_req_valid_o)), 32'd0);

	held_valid: assert property (@(posedge clock) disable iff (reset)
		held |-> fetch_req_valid_o)
		else report_mismatch("fetch_req_valid_o", 32'($sampled(fetch_req_valid_o)), 32'd1);

	held_addr: assert property (@(posedge clock) disable iff (reset)
		held |-> fetch_addr_o == prev_addr)
		else report_mismatch("fetch_addr_o", $sampled(fetch_addr_o), $sampled(prev_addr));

endmodule

// ==== bench/rv32_iss.sv ====
`include "rv32_consts.svh"

// instruction-set reference, one step per commit
module rv32_iss import rv32_pkg::*; (
	input  logic      clock_i,
	input  logic      reset_i,
	input  logic      step_i,
	input  inst_t     inst_i,
	output word_t     pc_o,
	output word_t     next_pc_o,
	output logic      wen_o,
	output reg_addr_t rd_o,
	output word_t     data_o
);
	timeunit 1ns;
	timeprecision 100ps;

	word_t      x [0:31];
	word_t      pc;
	word_t      src1;
	word_t      src2;
	word_t      imm_i;
	word_t      imm_u;
	word_t      operand;
	logic [6:0] opcode;
	logic [2:0] f3;
	logic       writes;

	function automatic word_t arith(logic [2:0] funct3, logic alt, word_t a, word_t b);
		case (funct3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) begin
					return $signed(a) >>> b[4:0];
				end
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(logic [2:0] funct3, word_t a, word_t b);
		case (funct3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	always_comb begin
		opcode = inst_i[6:0];
		f3 = inst_i[14:12];
		src1 = x[inst_i[19:15]];
		src2 = x[inst_i[24:20]];
		imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
		imm_u = {inst_i[31:12], 12'b0};
		operand = (opcode == `RV32_OPC_OP) ? src2 : imm_i;
		data_o = '0;
		writes = 1'b0;
		next_pc_o = pc + 32'd4;
		case (opcode)
			`RV32_OPC_LUI: begin
				data_o = imm_u;
				writes = 1'b1;
			end
			`RV32_OPC_AUIPC: begin
				data_o = pc + imm_u;
				writes = 1'b1;
			end
			`RV32_OPC_JAL: begin
				data_o = pc + 32'd4;
				writes = 1'b1;
				next_pc_o = pc + {{12{inst_i[31]}}, inst_i[19:12], inst_i[20],
					inst_i[30:21], 1'b0};
			end
			`RV32_OPC_JALR: begin
				data_o = pc + 32'd4;
				writes = 1'b1;
				next_pc_o = (src1 + imm_i) & ~32'd1;
			end
			`RV32_OPC_BRANCH: begin
				if (branch_taken(f3, src1, src2)) begin
					next_pc_o = pc + {{20{inst_i[31]}}, inst_i[7], inst_i[30:25],
						inst_i[11:8], 1'b0};
				end
			end
			`RV32_OPC_OP_IMM, `RV32_OPC_OP: begin
				// bit 30 selects sub only for register ops
				data_o = arith(f3, inst_i[30] && (opcode == `RV32_OPC_OP || f3 == 3'd5),
					src1, operand);
				writes = 1'b1;
			end
			default: ;
		endcase
	end

	assign pc_o = pc;
	assign rd_o = inst_i[11:7];
	assign wen_o = writes && (inst_i[11:7] != 5'd0);

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			pc <= `RV32_RESET_PC;
			for (int i = 0; i < 32; i++) begin
				x[i] <= '0;
			end
		end else if (step_i) begin
			if (wen_o) begin
				x[rd_o] <= data_o;
			end
			pc <= next_pc_o;
		end
	end

endmodule

// ==== rtl/rv32_pipe_top.sv ====
module rv32_pipe_top import rv32_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	output logic      fetch_req_valid_o,
	output word_t     fetch_addr_o,
	input  logic      fetch_req_ready_i,
	input  logic      fetch_rsp_valid_i,
	input  inst_t     fetch_rsp_inst_i,
	output logic      commit_valid_o,
	output word_t     commit_pc_o,
	output inst_t     commit_inst_o,
	output logic      commit_wen_o,
	output reg_addr_t commit_rd_o,
	output word_t     commit_data_o
);
	logic  fetch_valid;
	word_t fetch_pc;
	inst_t fetch_inst;
	logic  redirect_valid;
	word_t redirect_pc;

	issue_if  issue ();
	result_if ex_result ();
	result_if rt_result ();

	fetch_unit u_fetch (
		.clock_i           (clock),
		.reset_i           (reset),
		.fetch_req_valid_o (fetch_req_valid_o),
		.fetch_addr_o      (fetch_addr_o),
		.fetch_req_ready_i (fetch_req_ready_i),
		.fetch_rsp_valid_i (fetch_rsp_valid_i),
		.fetch_rsp_inst_i  (fetch_rsp_inst_i),
		.redirect_valid_i  (redirect_valid),
		.redirect_pc_i     (redirect_pc),
		.fetch_valid_o     (fetch_valid),
		.fetch_pc_o        (fetch_pc),
		.fetch_inst_o      (fetch_inst)
	);

	decode_stage u_decode (
		.clock_i       (clock),
		.reset_i       (reset),
		.fetch_valid_i (fetch_valid),
		.fetch_pc_i    (fetch_pc),
		.fetch_inst_i  (fetch_inst),
		.issue         (issue.producer),
		.ex_fwd        (ex_result.consumer),
		.rt_fwd        (rt_result.monitor)
	);

	execute_stage u_execute (
		.clock_i          (clock),
		.reset_i          (reset),
		.issue            (issue.consumer),
		.result           (ex_result.producer),
		.redirect_valid_o (redirect_valid),
		.redirect_pc_o    (redirect_pc)
	);

	retire_unit u_retire (
		.clock_i        (clock),
		.reset_i        (reset),
		.ex_in          (ex_result.consumer),
		.rt_out         (rt_result.producer),
		.commit_valid_o (commit_valid_o),
		.commit_wen_o   (commit_wen_o),
		.commit_pc_o    (commit_pc_o),
		.commit_data_o  (commit_data_o),
		.commit_inst_o  (commit_inst_o),
		.commit_rd_o    (commit_rd_o)
	);

endmodule

// ==== rtl/retire_unit.sv ====
module retire_unit import rv32_pkg::*; (
	input  logic       clock_i,
	input  logic       reset_i,
	result_if.consumer ex_in,
	result_if.producer rt_out,
	output logic       commit_valid_o,
	output logic       commit_wen_o,
	output word_t      commit_pc_o,
	output word_t      commit_data_o,
	output inst_t      commit_inst_o,
	output reg_addr_t  commit_rd_o
);
	logic      rt_valid;
	word_t     rt_pc;
	inst_t     rt_inst;
	reg_addr_t rt_rd;
	logic      rt_wen;
	word_t     rt_data;

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			rt_valid <= 1'b0;
		end else begin
			rt_valid <= ex_in.valid;
		end
	end

	always_ff @(posedge clock_i) begin
		if (ex_in.valid) begin
			rt_pc <= ex_in.pc;
			rt_inst <= ex_in.inst;
			rt_rd <= ex_in.rd;
			rt_wen <= ex_in.wen;
			rt_data <= ex_in.result;
		end
	end

	// regfile write and older forwarding source
	assign rt_out.valid = rt_valid;
	assign rt_out.pc = rt_pc;
	assign rt_out.inst = rt_inst;
	assign rt_out.rd = rt_rd;
	assign rt_out.wen = rt_wen;
	assign rt_out.result = rt_data;

	assign commit_valid_o = rt_valid;
	assign commit_wen_o = rt_wen;
	assign commit_pc_o = rt_pc;
	assign commit_data_o = rt_data;
	assign commit_inst_o = rt_inst;
	assign commit_rd_o = rt_rd;

endmodule

// ==== rtl/execute_stage.sv ====
`include "rv32_consts.svh"

module execute_stage import rv32_pkg::*; (
	input  logic       clock_i,
	input  logic       reset_i,
	issue_if.consumer  issue,
	result_if.producer result,
	output logic       redirect_valid_o,
	output word_t      redirect_pc_o
);
	word_t a;
	word_t b;
	word_t alu_res;
	word_t link;
	word_t target;
	logic  is_ctrl;
	logic  is_jump;
	logic  taken;
	logic  redirect_q;

	assign a = issue.operand_a;
	assign b = issue.operand_b;
	assign link = issue.pc + 32'd4;

	always_comb begin
		case (issue.alu_op)
			`ALU_ADD:  alu_res = a + b;
			`ALU_SUB:  alu_res = a - b;
			`ALU_SLL:  alu_res = a << b[4:0];
			`ALU_SLT:  alu_res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			`ALU_SLTU: alu_res = (a < b) ? 32'd1 : 32'd0;
			`ALU_XOR:  alu_res = a ^ b;
			`ALU_SRL:  alu_res = a >> b[4:0];
			`ALU_SRA:  alu_res = $signed(a) >>> b[4:0];
			`ALU_OR:   alu_res = a | b;
			`ALU_AND:  alu_res = a & b;
			default:   alu_res = '0;
		endcase
	end

	// rs1 vs rs2 by funct3
	always_comb begin
		case (issue.inst[14:12])
			3'b000:  taken = (a == issue.rs2_value);
			3'b001:  taken = (a != issue.rs2_value);
			3'b100:  taken = ($signed(a) < $signed(issue.rs2_value));
			3'b101:  taken = ($signed(a) >= $signed(issue.rs2_value));
			3'b110:  taken = (a < issue.rs2_value);
			3'b111:  taken = (a >= issue.rs2_value);
			default: taken = 1'b0;
		endcase
	end

	assign is_ctrl = (issue.ctrl != `RV32_CTRL_NONE);
	assign is_jump = (issue.ctrl == `RV32_CTRL_JAL) || (issue.ctrl == `RV32_CTRL_JALR);

	// operand_a holds pc for jal and rs1 for jalr
	always_comb begin
		if (issue.ctrl == `RV32_CTRL_BRANCH) begin
			target = issue.pc + issue.imm;
		end else begin
			target = a + issue.imm;
		end
		if (issue.ctrl == `RV32_CTRL_JALR) begin
			target[0] = 1'b0;
		end
	end

	// one redirect per control instruction
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			redirect_q <= 1'b0;
		end else begin
			redirect_q <= redirect_valid_o;
		end
	end

	assign redirect_valid_o = issue.valid && is_ctrl && !redirect_q;
	assign redirect_pc_o = (is_jump || taken) ? target : link;

	assign result.valid = issue.valid;
	assign result.pc = issue.pc;
	assign result.inst = issue.inst;
	assign result.rd = issue.rd;
	assign result.wen = issue.wen;
	assign result.result = is_jump ? link : alu_res;

endmodule

// ==== rtl/fetch_unit.sv ====
`include "rv32_consts.svh"

module fetch_unit import rv32_pkg::*; (
	input  logic  clock_i,
	input  logic  reset_i,
	output logic  fetch_req_valid_o,
	output word_t fetch_addr_o,
	input  logic  fetch_req_ready_i,
	input  logic  fetch_rsp_valid_i,
	input  inst_t fetch_rsp_inst_i,
	input  logic  redirect_valid_i,
	input  word_t redirect_pc_i,
	output logic  fetch_valid_o,
	output word_t fetch_pc_o,
	output inst_t fetch_inst_o
);
	fetch_state_t state;
	word_t        pc;
	logic         req_valid;
	logic [6:0]   rsp_opcode;
	logic         rsp_is_ctrl;

	// pre-decode of the returned word
	assign rsp_opcode = fetch_rsp_inst_i[6:0];
	assign rsp_is_ctrl = (rsp_opcode == `RV32_OPC_JAL) ||
		(rsp_opcode == `RV32_OPC_JALR) ||
		(rsp_opcode == `RV32_OPC_BRANCH);

	assign fetch_req_valid_o = req_valid;
	assign fetch_addr_o = pc;

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state <= FETCH_IDLE;
			req_valid <= 1'b0;
			pc <= `RV32_RESET_PC;
		end else begin
			case (state)
				FETCH_IDLE: begin
					if (req_valid && fetch_req_ready_i) begin
						req_valid <= 1'b0;
						state <= FETCH_WAIT_RSP;
					end else begin
						req_valid <= 1'b1;
					end
				end
				FETCH_WAIT_RSP: begin
					if (fetch_rsp_valid_i) begin
						if (rsp_is_ctrl) begin
							// hold until execute resolves the target
							state <= FETCH_WAIT_REDIRECT;
						end else begin
							pc <= pc + 32'd4;
							req_valid <= 1'b1;
							state <= FETCH_IDLE;
						end
					end
				end
				FETCH_WAIT_REDIRECT: begin
					if (redirect_valid_i) begin
						pc <= redirect_pc_i;
						req_valid <= 1'b1;
						state <= FETCH_IDLE;
					end
				end
				default: state <= FETCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			fetch_valid_o <= 1'b0;
		end else begin
			fetch_valid_o <= fetch_rsp_valid_i;
		end
	end

	always_ff @(posedge clock_i) begin
		if (fetch_rsp_valid_i) begin
			fetch_pc_o <= pc;
			fetch_inst_o <= fetch_rsp_inst_i;
		end
	end

endmodule

// ==== rtl/decode/decode_stage.sv ====
`include "rv32_consts.svh"

module decode_stage import rv32_pkg::*; (
	input  logic       clock_i,
	input  logic       reset_i,
	input  logic       fetch_valid_i,
	input  word_t      fetch_pc_i,
	input  inst_t      fetch_inst_i,
	issue_if.producer  issue,
	result_if.consumer ex_fwd,
	result_if.monitor  rt_fwd
);
	logic [6:0]              opcode;
	logic [2:0]              funct3;
	reg_addr_t               rd;
	reg_addr_t               rs1;
	reg_addr_t               rs2;
	word_t                   rs1_rf;
	word_t                   rs2_rf;
	word_t                   rs1_val;
	word_t                   rs2_val;
	logic                    ex_hit1;
	logic                    ex_hit2;
	logic                    rt_hit1;
	logic                    rt_hit2;
	word_t                   imm_i;
	word_t                   imm_b;
	word_t                   imm_u;
	word_t                   imm_j;
	word_t                   imm;
	word_t                   op_a;
	word_t                   op_b;
	alu_op_t                 funct_op;
	alu_op_t                 alu_op;
	logic [`RV32_CTRL_W-1:0] ctrl;
	logic                    writes;

	assign opcode = fetch_inst_i[6:0];
	assign funct3 = fetch_inst_i[14:12];
	assign rd = fetch_inst_i[11:7];
	assign rs1 = fetch_inst_i[19:15];
	assign rs2 = fetch_inst_i[24:20];

	assign imm_i = {{20{fetch_inst_i[31]}}, fetch_inst_i[31:20]};
	assign imm_b = {{19{fetch_inst_i[31]}}, fetch_inst_i[31], fetch_inst_i[7],
		fetch_inst_i[30:25], fetch_inst_i[11:8], 1'b0};
	assign imm_u = {fetch_inst_i[31:12], 12'b0};
	assign imm_j = {{11{fetch_inst_i[31]}}, fetch_inst_i[31], fetch_inst_i[19:12],
		fetch_inst_i[20], fetch_inst_i[30:21], 1'b0};

	register_file u_regfile (
		.clock_i    (clock_i),
		.reset_i    (reset_i),
		.rs1_addr_i (rs1),
		.rs2_addr_i (rs2),
		.rs1_data_o (rs1_rf),
		.rs2_data_o (rs2_rf),
		.wr         (rt_fwd)
	);

	// youngest producer wins
	assign ex_hit1 = ex_fwd.valid && ex_fwd.wen && (ex_fwd.rd == rs1);
	assign ex_hit2 = ex_fwd.valid && ex_fwd.wen && (ex_fwd.rd == rs2);
	assign rt_hit1 = rt_fwd.valid && rt_fwd.wen && (rt_fwd.rd == rs1);
	assign rt_hit2 = rt_fwd.valid && rt_fwd.wen && (rt_fwd.rd == rs2);

	assign rs1_val = (rs1 == '0) ? '0 : ex_hit1 ? ex_fwd.result :
		rt_hit1 ? rt_fwd.result : rs1_rf;
	assign rs2_val = (rs2 == '0) ? '0 : ex_hit2 ? ex_fwd.result :
		rt_hit2 ? rt_fwd.result : rs2_rf;

	// shared by OP and OP-IMM, sub only exists for OP
	always_comb begin
		case (funct3)
			3'b000: funct_op = (opcode == `RV32_OPC_OP && fetch_inst_i[30]) ? `ALU_SUB : `ALU_ADD;
			3'b001: funct_op = `ALU_SLL;
			3'b010: funct_op = `ALU_SLT;
			3'b011: funct_op = `ALU_SLTU;
			3'b100: funct_op = `ALU_XOR;
			3'b101: funct_op = fetch_inst_i[30] ? `ALU_SRA : `ALU_SRL;
			3'b110: funct_op = `ALU_OR;
			default: funct_op = `ALU_AND;
		endcase
	end

	always_comb begin
		op_a = rs1_val;
		op_b = rs2_val;
		imm = imm_i;
		alu_op = `ALU_ADD;
		ctrl = `RV32_CTRL_NONE;
		writes = 1'b0;
		case (opcode)
			`RV32_OPC_LUI: begin
				op_a = '0;
				op_b = imm_u;
				imm = imm_u;
				writes = 1'b1;
			end
			`RV32_OPC_AUIPC: begin
				op_a = fetch_pc_i;
				op_b = imm_u;
				imm = imm_u;
				writes = 1'b1;
			end
			`RV32_OPC_JAL: begin
				op_a = fetch_pc_i;
				imm = imm_j;
				ctrl = `RV32_CTRL_JAL;
				writes = 1'b1;
			end
			`RV32_OPC_JALR: begin
				ctrl = `RV32_CTRL_JALR;
				writes = 1'b1;
			end
			`RV32_OPC_BRANCH: begin
				imm = imm_b;
				ctrl = `RV32_CTRL_BRANCH;
			end
			`RV32_OPC_OP_IMM: begin
				op_b = imm_i;
				alu_op = funct_op;
				writes = 1'b1;
			end
			`RV32_OPC_OP: begin
				alu_op = funct_op;
				writes = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			issue.valid <= 1'b0;
		end else begin
			issue.valid <= fetch_valid_i;
		end
	end

	always_ff @(posedge clock_i) begin
		if (fetch_valid_i) begin
			issue.pc <= fetch_pc_i;
			issue.inst <= fetch_inst_i;
			issue.alu_op <= alu_op;
			issue.operand_a <= op_a;
			issue.operand_b <= op_b;
			issue.rs2_value <= rs2_val;
			issue.imm <= imm;
			issue.rd <= rd;
			issue.wen <= writes && (rd != '0);
			issue.ctrl <= ctrl;
		end
	end

endmodule

// ==== rtl/decode/register_file.sv ====
`include "rv32_consts.svh"

module register_file import rv32_pkg::*; (
	input  logic             clock_i,
	input  logic             reset_i,
	input  reg_addr_t        rs1_addr_i,
	input  reg_addr_t        rs2_addr_i,
	output word_t            rs1_data_o,
	output word_t            rs2_data_o,
	result_if.monitor        wr
);
	// x0 is not stored
	word_t regs [1:31];

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.valid && wr.wen && (wr.rd != '0)) begin
			regs[wr.rd] <= wr.result;
		end
	end

	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== common/stage_if.sv ====
`include "rv32_consts.svh"

// decode to execute bundle
interface issue_if import rv32_pkg::*; ();
	logic                    valid;
	word_t                   pc;
	inst_t                   inst;
	alu_op_t                 alu_op;
	word_t                   operand_a;
	word_t                   operand_b;
	word_t                   rs2_value;
	word_t                   imm;
	reg_addr_t               rd;
	logic                    wen;
	logic [`RV32_CTRL_W-1:0] ctrl;

	modport producer (
		output valid, pc, inst, alu_op, operand_a, operand_b, rs2_value, imm, rd, wen, ctrl
	);
	modport consumer (
		input valid, pc, inst, alu_op, operand_a, operand_b, rs2_value, imm, rd, wen, ctrl
	);
endinterface

// executed instruction and its write-back value
interface result_if import rv32_pkg::*; ();
	logic      valid;
	word_t     pc;
	inst_t     inst;
	reg_addr_t rd;
	logic      wen;
	word_t     result;

	modport producer (output valid, pc, inst, rd, wen, result);
	modport consumer (input valid, pc, inst, rd, wen, result);
	modport monitor (input valid, pc, inst, rd, wen, result);
endinterface

// ==== common/rv32_pkg.sv ====
`include "rv32_consts.svh"

package rv32_pkg;

	typedef logic [`RV32_XLEN-1:0] word_t;

	typedef logic [`RV32_XLEN-1:0] inst_t;

	typedef logic [`RV32_REG_AW-1:0] reg_addr_t;

	typedef logic [`RV32_ALU_W-1:0] alu_op_t;

	// at most one fetch request in flight
	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_WAIT_RSP,
		FETCH_WAIT_REDIRECT
	} fetch_state_t;

endpackage

// ==== common/rv32_consts.svh ====
`ifndef RV32_CONSTS_SVH
`define RV32_CONSTS_SVH

`define RV32_XLEN      32
`define RV32_REG_AW    5
`define RV32_ALU_W     4
`define RV32_CTRL_W    2
`define RV32_RESET_PC  32'h0000_0000

// base opcodes, inst[6:0]
`define RV32_OPC_LUI     7'b0110111
`define RV32_OPC_AUIPC   7'b0010111
`define RV32_OPC_JAL     7'b1101111
`define RV32_OPC_JALR    7'b1100111
`define RV32_OPC_BRANCH  7'b1100011
`define RV32_OPC_OP_IMM  7'b0010011
`define RV32_OPC_OP      7'b0110011

`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_SLL   4'd2
`define ALU_SLT   4'd3
`define ALU_SLTU  4'd4
`define ALU_XOR   4'd5
`define ALU_SRL   4'd6
`define ALU_SRA   4'd7
`define ALU_OR    4'd8
`define ALU_AND   4'd9

// control kind carried to execute
`define RV32_CTRL_NONE    2'd0
`define RV32_CTRL_BRANCH  2'd1
`define RV32_CTRL_JAL     2'd2
`define RV32_CTRL_JALR    2'd3

`endif
